// File: compile.f
+incdir+rtl
rtl/div_pkg.sv
rtl/div_apb_regs.sv
rtl/div_core.sv
rtl/div_result.sv
rtl/div_top.sv
sim/div_asserts.sv
sim/div_tb.sv

// File: run.sh
#!/bin/sh
# builds the divider testbench with Verilator and runs it once
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/100ps --top-module div_tb \
	-f compile.f -o div_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/div_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "Everything OK"; then
	exit 0
fi
echo "simulation did not report a pass"
exit 1

// File: sim/div_tb.sv
/* testbench for the APB divider peripheral, drives register accesses like software would
 * and checks every quotient and status word against a reference divide */
`include "div_settings.svh"

module div_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int READY_LIMIT = 8;
	localparam int POLL_LIMIT  = 100;

	// one finished divide as the compare process sees it
	typedef struct packed {
		logic [`DIV_BW-1:0] numerator;
		logic [`DIV_BW-1:0] denominator;
		logic               is_signed;
		logic [`DIV_BW-1:0] quotient;
		logic [`DIV_BW-1:0] status;
	} div_obs_t;

	logic                   i_clk;
	logic                   i_reset;
	logic                   i_psel;
	logic                   i_penable;
	logic                   i_pwrite;
	logic [`DIV_APB_AW-1:0] i_paddr;
	logic [`DIV_BW-1:0]     i_pwdata;
	logic [`DIV_BW-1:0]     o_prdata;
	logic                   o_pready;
	logic                   o_pslverr;

	div_obs_t obs_q[$];
	integer   seed;

	div_top div_top_i (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr)
	);

	always #20 i_clk = ~i_clk;

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic stop_on_timeout(input string what);
		$display("timed out while waiting for %s", what);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input logic [`DIV_BW-1:0] got,
		input logic [`DIV_BW-1:0] exp);
		$display("** Error: %s got %h expected %h", name, got, exp);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_slverr(input logic got, input logic exp);
		assert (got == exp) else report_mismatch("o_pslverr", 32'(got), 32'(exp));
	endtask

	////////////////////////////////////////////////////////////
	// APB master
	////////////////////////////////////////////////////////////

	// setup phase, then access phase held until PREADY, sampled at the falling edge
	task automatic apb_access(input logic write, input logic [`DIV_APB_AW-1:0] addr,
		input logic [`DIV_BW-1:0] wdata, output logic [`DIV_BW-1:0] rdata, output logic slverr);
		int n;
		@(posedge i_clk);
		i_psel    <= 1'b1;
		i_penable <= 1'b0;
		i_pwrite  <= write;
		i_paddr   <= addr;
		i_pwdata  <= wdata;
		@(posedge i_clk);
		i_penable <= 1'b1;
		n = 0;
		@(negedge i_clk);
		while (!o_pready) begin
			if (n == READY_LIMIT) begin
				stop_on_timeout("PREADY");
			end
			n++;
			@(negedge i_clk);
		end
		rdata  = o_prdata;
		slverr = o_pslverr;
		// the access completes on this edge, the bus goes idle with it
		@(posedge i_clk);
		i_psel    <= 1'b0;
		i_penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [`DIV_APB_AW-1:0] addr, input logic [`DIV_BW-1:0] wdata,
		output logic slverr);
		logic [`DIV_BW-1:0] ignored;
		apb_access(1'b1, addr, wdata, ignored, slverr);
	endtask

	task automatic apb_read(input logic [`DIV_APB_AW-1:0] addr, output logic [`DIV_BW-1:0] rdata,
		output logic slverr);
		apb_access(1'b0, addr, '0, rdata, slverr);
	endtask

	////////////////////////////////////////////////////////////
	// reference model and compare
	////////////////////////////////////////////////////////////

	// expected quotient and STATUS word once the divide is done
	function automatic void ref_divide(input logic [`DIV_BW-1:0] num,
		input logic [`DIV_BW-1:0] den, input logic sgn,
		output logic [`DIV_BW-1:0] quot, output logic [`DIV_BW-1:0] status);
		logic               err;
		logic               ovf;
		logic [3:0]         flags;
		logic [`DIV_BW-1:0] most_neg;
		most_neg = {1'b1, {(`DIV_BW-1){1'b0}}};
		err      = (den == '0);
		ovf      = sgn && !err && (num == most_neg) && (den == '1);
		if (err) begin
			quot = '1;
		end else if (ovf) begin
			quot = most_neg;
		end else if (sgn) begin
			quot = $signed(num) / $signed(den);
		end else begin
			quot = num / den;
		end
		flags[0]    = (quot == '0);
		flags[1]    = err;
		flags[2]    = sgn & quot[`DIV_BW-1];
		flags[3]    = ovf;
		status      = '0;
		status[1]   = 1'b1;
		status[2]   = err;
		status[7:4] = flags;
	endfunction

	// observations are pushed at rising edges, so popping them at falling edges is race free
	always @(negedge i_clk) begin : compare
		div_obs_t           obs;
		logic [`DIV_BW-1:0] exp_q;
		logic [`DIV_BW-1:0] exp_s;
		while (obs_q.size() > 0) begin
			obs = obs_q.pop_front();
			ref_divide(obs.numerator, obs.denominator, obs.is_signed, exp_q, exp_s);
			assert (obs.quotient == exp_q) else report_mismatch("QUOT", obs.quotient, exp_q);
			assert (obs.status == exp_s) else report_mismatch("STATUS", obs.status, exp_s);
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	// one full software sequence, optionally with a second start while the core runs
	task automatic run_divide(input logic [`DIV_BW-1:0] num, input logic [`DIV_BW-1:0] den,
		input logic sgn, input logic poke_busy);
		div_obs_t           obs;
		logic [`DIV_BW-1:0] rd;
		logic               err;
		int                 n;
		apb_write(div_pkg::REG_NUMER, num, err);
		check_slverr(err, 1'b0);
		apb_write(div_pkg::REG_DENOM, den, err);
		check_slverr(err, 1'b0);
		apb_write(div_pkg::REG_CTRL, {30'b0, sgn, 1'b1}, err);
		check_slverr(err, 1'b0);
		// the start has already cleared done by the time this read samples it
		apb_read(div_pkg::REG_STATUS, rd, err);
		assert (rd[1] == 1'b0) else report_mismatch("STATUS.done", 32'(rd[1]), 32'h0);
		if (poke_busy) begin
			apb_write(div_pkg::REG_CTRL, {30'b0, ~sgn, 1'b1}, err);
			check_slverr(err, 1'b1);
		end
		n = 0;
		while (!rd[1]) begin
			if (n == POLL_LIMIT) begin
				stop_on_timeout("the done bit");
			end
			n++;
			apb_read(div_pkg::REG_STATUS, rd, err);
		end
		assert (rd[0] == 1'b0) else report_mismatch("STATUS.busy", 32'(rd[0]), 32'h0);
		obs.status = rd;
		apb_read(div_pkg::REG_QUOT, obs.quotient, err);
		obs.numerator   = num;
		obs.denominator = den;
		obs.is_signed   = sgn;
		obs_q.push_back(obs);
	endtask

	initial begin
		logic [`DIV_BW-1:0] num;
		logic [`DIV_BW-1:0] den;
		logic [`DIV_BW-1:0] rd;
		logic               err;
		int                 n;
		seed      = 32'h203c;
		i_clk     = 1'b0;
		i_reset   = 1'b1;
		i_psel    = 1'b0;
		i_penable = 1'b0;
		i_pwrite  = 1'b0;
		i_paddr   = '0;
		i_pwdata  = '0;
		repeat (4) @(posedge i_clk);
		i_reset <= 1'b0;

		// unsigned, with the denominator shrinking so quotients get wide
		for (int i = 0; i < 12; i++) begin
			num = $random(seed);
			den = $random(seed) >> (i * 2);
			run_divide(num, den, 1'b0, 1'b0);
		end

		// signed, the two low loop bits pick the operand signs
		for (int i = 0; i < 16; i++) begin
			num     = $random(seed);
			den     = $random(seed) >> (1 + i);
			num[31] = i[0];
			if (i[1]) begin
				den = -den;
			end
			run_divide(num, den, 1'b1, 1'b0);
		end

		// division by zero in both modes
		run_divide(32'h1234_5678, 32'h0, 1'b0, 1'b0);
		run_divide(32'h8765_4321, 32'h0, 1'b1, 1'b0);

		// signed overflow, and the same operands unsigned for contrast
		run_divide(32'h8000_0000, 32'hffff_ffff, 1'b1, 1'b0);
		run_divide(32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0);

		// a start while busy is refused and leaves the running divide alone
		run_divide(32'hdead_beef, 32'h0000_0123, 1'b0, 1'b1);
		run_divide(32'h9abc_def0, 32'h0000_0077, 1'b1, 1'b1);

		// an offset outside the register map
		apb_read(5'h14, rd, err);
		check_slverr(err, 1'b1);

		n = 0;
		while (obs_q.size() > 0) begin
			if (n == 10) begin
				stop_on_timeout("the compare process");
			end
			n++;
			@(posedge i_clk);
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// File: sim/div_asserts.sv
/* concurrent handshake checks on the divider core, attached to every div_core by bind */
module div_asserts (
	input logic                i_clk,
	input logic                i_reset,
	input logic                i_start,
	input logic                i_busy,
	input logic                i_valid,
	input div_pkg::div_state_e i_state
);
	timeunit 1ns;
	timeprecision 100ps;

	// the result pulse belongs to the idle side of the FSM
	busy_valid_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_busy && i_valid))
		else $error("busy and valid are high in the same cycle");

	// the register block holds back any start while the core is still working
	start_when_idle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start |-> (i_state == div_pkg::DIV_IDLE))
		else $error("start arrived while the core was not idle");

	// every start moves the core into presign on the next edge
	start_to_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_start |=> i_busy)
		else $error("start was not followed by busy");

	valid_after_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		i_valid |-> $fell(i_busy))
		else $error("valid did not coincide with the fall of busy");

	valid_one_cycle: assert property (@(posedge i_clk) disable iff (i_reset)
		i_valid |=> !i_valid)
		else $error("valid stayed high for more than one cycle");

endmodule

bind div_core div_asserts div_asserts_i (
	.i_clk   (i_clk),
	.i_reset (i_reset),
	.i_start (i_start),
	.i_busy  (o_busy),
	.i_valid (o_valid),
	.i_state (r_state)
);

// File: rtl/div_top.sv
/* APB divider peripheral: register block, divider core and result stage */
`include "div_settings.svh"

module div_top (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [`DIV_APB_AW-1:0] i_paddr,
	input  logic [`DIV_BW-1:0]     i_pwdata,
	output logic [`DIV_BW-1:0]     o_prdata,
	output logic                   o_pready,
	output logic                   o_pslverr
);

	logic              start;
	logic              busy;
	logic              valid;
	logic              done;
	logic [3:0]        flags;
	div_pkg::div_op_t  op;
	div_pkg::div_res_t core_res;
	div_pkg::div_res_t held_res;

	// software side, operands in and status out
	div_apb_regs div_apb_regs_i (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.i_busy    (busy),
		.i_done    (done),
		.i_res     (held_res),
		.i_flags   (flags),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.o_start   (start),
		.o_op      (op)
	);

	div_core div_core_i (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_start (start),
		.i_op    (op),
		.o_busy  (busy),
		.o_valid (valid),
		.o_res   (core_res)
	);

	// is_signed is only updated by an accepted start, so it matches the result
	div_result div_result_i (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_start  (start),
		.i_valid  (valid),
		.i_res    (core_res),
		.i_signed (op.is_signed),
		.o_res    (held_res),
		.o_done   (done),
		.o_flags  (flags)
	);

endmodule

// File: rtl/div_result.sv
/* holds the last divide result with a sticky done bit and derives the condition flags
 * a new start clears done; the result itself stays until the next one arrives */
`include "div_settings.svh"

module div_result (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_start,
	input  logic              i_valid,
	input  div_pkg::div_res_t i_res,
	input  logic              i_signed,
	output div_pkg::div_res_t o_res,
	output logic              o_done,
	output logic [3:0]        o_flags
);

	div_pkg::div_res_t r_res;
	logic              r_signed;

	// done is set on the same edge that captures the result
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_done <= 1'b0;
		end else if (i_start) begin
			o_done <= 1'b0;
		end else if (i_valid) begin
			o_done <= 1'b1;
		end
	end

	// keep the sign mode with the result so the flags stay consistent
	always_ff @(posedge i_clk) begin
		if (i_valid) begin
			r_res    <= i_res;
			r_signed <= i_signed;
		end
	end

	assign o_res = r_res;

	// zero, error, negative (signed only) and overflow
	assign o_flags[0] = (r_res.quotient == '0);
	assign o_flags[1] = r_res.err;
	assign o_flags[2] = r_signed & r_res.quotient[`DIV_BW-1];
	assign o_flags[3] = r_res.ovf;

endmodule

// File: rtl/div_core.sv
/* iterative restoring divider, signed or unsigned, one quotient bit per clock
 * pulse i_start from idle; o_valid pulses once in the cycle busy drops */
`include "div_settings.svh"

module div_core (
	input  logic              i_clk,
	input  logic              i_reset,
	input  logic              i_start,
	input  div_pkg::div_op_t  i_op,
	output logic              o_busy,
	output logic              o_valid,
	output div_pkg::div_res_t o_res
);

	// the divisor register holds the denominator shifted up by DIV_BW-1
	localparam int DW = 2 * `DIV_BW - 1;

	div_pkg::div_state_e  r_state;
	logic [`DIV_BW-1:0]   r_dividend;
	logic [DW-1:0]        r_divisor;
	logic [`DIV_BW-1:0]   r_quotient;
	logic [`DIV_LGBW-1:0] r_count;
	logic                 r_signed;
	logic                 r_sign;
	logic                 r_err;
	logic                 r_ovf;

	logic [`DIV_BW-1:0]   den_top;
	logic                 neg_num;
	logic                 neg_den;
	logic [DW-1:0]        rem_ext;
	logic [DW-1:0]        diff;
	logic                 fits;

	////////////////////////////////////////////////////////////
	// combinational helpers
	////////////////////////////////////////////////////////////

	// the denominator still sits in the top bits during presign
	assign den_top = r_divisor[DW-1 -: `DIV_BW];

	// operands only count as negative in a signed divide
	assign neg_num = r_signed & r_dividend[`DIV_BW-1];
	assign neg_den = r_signed & den_top[`DIV_BW-1];

	// compare the remaining dividend against the shifted divisor
	assign rem_ext = {{(`DIV_BW-1){1'b0}}, r_dividend};
	assign fits    = (r_divisor <= rem_ext);
	assign diff    = rem_ext - r_divisor;

	////////////////////////////////////////////////////////////
	// control FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			r_state <= div_pkg::DIV_IDLE;
			o_valid <= 1'b0;
		end else begin
			o_valid <= 1'b0;
			case (r_state)
			div_pkg::DIV_IDLE: begin
				if (i_start) begin
					r_state <= div_pkg::DIV_PRESIGN;
				end
			end
			div_pkg::DIV_PRESIGN: begin
				r_state <= div_pkg::DIV_SHIFT;
			end
			div_pkg::DIV_SHIFT: begin
				// the last quotient bit goes in when the counter reads one
				if (r_count == `DIV_LGBW'(1)) begin
					r_state <= div_pkg::DIV_NEGATE;
				end
			end
			div_pkg::DIV_NEGATE: begin
				r_state <= div_pkg::DIV_IDLE;
				o_valid <= 1'b1;
			end
			default: begin
				r_state <= div_pkg::DIV_IDLE;
			end
			endcase
		end
	end

	// busy covers presign, every shift and negate
	assign o_busy = (r_state != div_pkg::DIV_IDLE);

	////////////////////////////////////////////////////////////
	// datapath
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		case (r_state)
		div_pkg::DIV_IDLE: begin
			if (i_start) begin
				r_dividend <= i_op.numerator;
				r_divisor  <= {i_op.denominator, {(`DIV_BW-1){1'b0}}};
				r_signed   <= i_op.is_signed;
				r_count    <= `DIV_LGBW'(`DIV_BW);
			end
		end
		div_pkg::DIV_PRESIGN: begin
			// turn a signed divide into an unsigned one and remember the sign
			r_dividend <= neg_num ? -r_dividend : r_dividend;
			r_divisor  <= {(neg_den ? -den_top : den_top), {(`DIV_BW-1){1'b0}}};
			r_sign     <= neg_num ^ neg_den;
			r_quotient <= '0;
			r_err      <= (den_top == '0);
			// the most negative value over minus one does not fit
			r_ovf      <= r_signed && (den_top == '1) &&
				(r_dividend == {1'b1, {(`DIV_BW-1){1'b0}}});
		end
		div_pkg::DIV_SHIFT: begin
			if (fits) begin
				r_dividend <= diff[`DIV_BW-1:0];
			end
			r_quotient <= {r_quotient[`DIV_BW-2:0], fits};
			r_divisor  <= r_divisor >> 1;
			r_count    <= r_count - `DIV_LGBW'(1);
		end
		div_pkg::DIV_NEGATE: begin
			// a zero denominator always reports all ones
			if (r_err) begin
				r_quotient <= '1;
			end else if (r_sign) begin
				r_quotient <= -r_quotient;
			end
		end
		default: begin
			r_count <= '0;
		end
		endcase
	end

	assign o_res.quotient = r_quotient;
	assign o_res.err      = r_err;
	assign o_res.ovf      = r_ovf;

endmodule

// File: rtl/div_apb_regs.sv
/* APB slave for the divider: operand registers, start control and status readback
 * zero wait states; a start while the core is busy completes with PSLVERR */
`include "div_settings.svh"

module div_apb_regs (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_psel,
	input  logic                   i_penable,
	input  logic                   i_pwrite,
	input  logic [`DIV_APB_AW-1:0] i_paddr,
	input  logic [`DIV_BW-1:0]     i_pwdata,
	input  logic                   i_busy,
	input  logic                   i_done,
	input  div_pkg::div_res_t      i_res,
	input  logic [3:0]             i_flags,
	output logic [`DIV_BW-1:0]     o_prdata,
	output logic                   o_pready,
	output logic                   o_pslverr,
	output logic                   o_start,
	output div_pkg::div_op_t       o_op
);

	////////////////////////////////////////////////////////////
	// access decode
	////////////////////////////////////////////////////////////

	div_pkg::div_reg_e reg_sel;
	logic              access;
	logic              wr_en;
	logic              addr_ok;
	logic              start_req;
	logic              refused;
	div_pkg::div_op_t  r_op;

	assign reg_sel = div_pkg::div_reg_e'(i_paddr);

	// the access phase is the only cycle where anything happens
	assign access = i_psel & i_penable;
	assign wr_en  = access & i_pwrite;

	// only the five defined offsets are mapped
	always_comb begin
		case (reg_sel)
		div_pkg::REG_NUMER,
		div_pkg::REG_DENOM,
		div_pkg::REG_CTRL,
		div_pkg::REG_STATUS,
		div_pkg::REG_QUOT: addr_ok = 1'b1;
		default:           addr_ok = 1'b0;
		endcase
	end

	// bit 0 of CTRL asks for a divide
	assign start_req = wr_en & (reg_sel == div_pkg::REG_CTRL) & i_pwdata[0];

	// o_start counts as busy too, since the core only raises busy a cycle later
	assign refused = start_req & (i_busy | o_start);

	assign o_pready  = 1'b1;
	assign o_pslverr = access & (~addr_ok | refused);

	////////////////////////////////////////////////////////////
	// operand registers and start pulse
	////////////////////////////////////////////////////////////

	// start is registered, so it shows up the cycle after the CTRL access
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_start <= 1'b0;
		end else begin
			o_start <= start_req & ~refused;
		end
	end

	// operands may be rewritten at any time, the core has its own copy
	always_ff @(posedge i_clk) begin
		if (wr_en && reg_sel == div_pkg::REG_NUMER) begin
			r_op.numerator <= i_pwdata;
		end
		if (wr_en && reg_sel == div_pkg::REG_DENOM) begin
			r_op.denominator <= i_pwdata;
		end
		// the sign mode only changes with an accepted start
		if (start_req && !refused) begin
			r_op.is_signed <= i_pwdata[1];
		end
	end

	assign o_op = r_op;

	////////////////////////////////////////////////////////////
	// read data
	////////////////////////////////////////////////////////////

	// read data follows the address directly, no wait states
	always_comb begin
		o_prdata = '0;
		case (reg_sel)
		div_pkg::REG_NUMER:  o_prdata = r_op.numerator;
		div_pkg::REG_DENOM:  o_prdata = r_op.denominator;
		div_pkg::REG_CTRL:   o_prdata[1] = r_op.is_signed;
		div_pkg::REG_STATUS: begin
			o_prdata[0]   = i_busy;
			o_prdata[1]   = i_done;
			o_prdata[2]   = i_res.err;
			o_prdata[7:4] = i_flags;
		end
		div_pkg::REG_QUOT:   o_prdata = i_res.quotient;
		default:             o_prdata = '0;
		endcase
	end

endmodule

// File: rtl/div_pkg.sv
/* types shared by the APB register block, the divider core and the result stage */
`include "div_settings.svh"

package div_pkg;

	// one divide request as the register block hands it to the core
	typedef struct packed {
		logic [`DIV_BW-1:0] numerator;
		logic [`DIV_BW-1:0] denominator;
		logic               is_signed;
	} div_op_t;

	// one finished divide, quotient plus the two error conditions
	typedef struct packed {
		logic [`DIV_BW-1:0] quotient;
		logic               err;
		logic               ovf;
	} div_res_t;

	// the core walks idle, presign, shift (DIV_BW times) and negate
	typedef enum logic [1:0] {
		DIV_IDLE    = 2'd0,
		DIV_PRESIGN = 2'd1,
		DIV_SHIFT   = 2'd2,
		DIV_NEGATE  = 2'd3
	} div_state_e;

	// register byte offsets inside the APB window
	typedef enum logic [`DIV_APB_AW-1:0] {
		REG_NUMER  = 'h00,
		REG_DENOM  = 'h04,
		REG_CTRL   = 'h08,
		REG_STATUS = 'h0C,
		REG_QUOT   = 'h10
	} div_reg_e;

endpackage

// File: rtl/div_settings.svh
/* width settings shared by the divider package and RTL modules
 * include this before using any of the DIV_ macros */
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand and quotient width in bits
`define DIV_BW 32

// the bit counter has to reach DIV_BW itself, hence one bit more than log2
`define DIV_LGBW 6

// byte address width of the APB register window
`define DIV_APB_AW 5

`endif
